/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // base opcodes
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;

    // load and store sizes
    localparam logic [2:0] FUNCT3_LB  = 3'b000;
    localparam logic [2:0] FUNCT3_LH  = 3'b001;
    localparam logic [2:0] FUNCT3_LW  = 3'b010;
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;
    localparam logic [2:0] FUNCT3_SB  = 3'b000;
    localparam logic [2:0] FUNCT3_SH  = 3'b001;
    localparam logic [2:0] FUNCT3_SW  = 3'b010;

    // branch conditions
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    // alu operations, shared by OP and OP_IMM
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SR      = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
    parameter logic [31:0] INITIAL_PC = 32'h0000_0000
) (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         count_i,
    input  wire         load_i,
    input  wire  [31:0] value_i,
    output logic [31:0] pc_o,
    output logic [31:0] pc_inc_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= INITIAL_PC;
        end else if (load_i) begin
            pc_o <= value_i;
        end else if (count_i) begin
            pc_o <= pc_inc_o;
        end
    end

    // link value for jumps
    assign pc_inc_o = pc_o + 32'd4;

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire         clk_i,
    input  wire  [4:0]  r_addr1_i,
    input  wire  [4:0]  r_addr2_i,
    output logic [31:0] r_data1_o,
    output logic [31:0] r_data2_o,
    input  wire         w_en_i,
    input  wire  [4:0]  w_addr_i,
    input  wire  [31:0] w_data_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (w_en_i && w_addr_i != 5'd0) begin
            regs[w_addr_i] <= w_data_i;
        end
        // x0 is never stored, so force zero on read
        r_data1_o <= (r_addr1_i == 5'd0) ? 32'd0 : regs[r_addr1_i];
        r_data2_o <= (r_addr2_i == 5'd0) ? 32'd0 : regs[r_addr2_i];
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
    input  wire  [31:0] instr_i,
    input  wire  [31:0] op_a_i,
    input  wire  [31:0] op_b_i,
    input  wire  [31:0] pc_i,
    output logic [31:0] result_o,
    output logic        eq_o,
    output logic        neq_o,
    output logic        lt_o,
    output logic        ltu_o,
    output logic        ge_o,
    output logic        geu_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  op;
    logic        alt;
    logic [31:0] res;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'd0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // operand pick, everything but OP and OP_IMM is an add
    always_comb begin
        a   = op_a_i;
        b   = imm_i;
        op  = FUNCT3_ADD_SUB;
        alt = 1'b0;
        case (opcode)
            OPCODE_OP: begin
                b   = op_b_i;
                op  = funct3;
                alt = instr_i[30];
            end
            OPCODE_OP_IMM: begin
                op  = funct3;
                // imm[10] selects srai, addi has no subtract
                alt = (funct3 == FUNCT3_SR) && instr_i[30];
            end
            OPCODE_STORE:  b = imm_s;
            OPCODE_AUIPC: begin
                a = pc_i;
                b = imm_u;
            end
            OPCODE_JAL: begin
                a = pc_i;
                b = imm_j;
            end
            OPCODE_BRANCH: begin
                a = pc_i;
                b = imm_b;
            end
            OPCODE_LUI: begin
                a = 32'd0;
                b = imm_u;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            FUNCT3_ADD_SUB: res = alt ? a - b : a + b;
            FUNCT3_SLL:     res = a << b[4:0];
            FUNCT3_SLT:     res = {31'd0, $signed(a) < $signed(b)};
            FUNCT3_SLTU:    res = {31'd0, a < b};
            FUNCT3_XOR:     res = a ^ b;
            FUNCT3_SR:      res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            FUNCT3_OR:      res = a | b;
            default:        res = a & b;
        endcase
    end

    assign result_o = (opcode == OPCODE_JALR) ? {res[31:1], 1'b0} : res;

    // branch compares always see the two registers
    assign eq_o  = op_a_i == op_b_i;
    assign neq_o = !eq_o;
    assign lt_o  = $signed(op_a_i) < $signed(op_b_i);
    assign ltu_o = op_a_i < op_b_i;
    assign ge_o  = !lt_o;
    assign geu_o = !ltu_o;

endmodule

`default_nettype wire

/* rtl/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import rv_pkg::*; #(
    parameter logic [31:0] INITIAL_PC = 32'h0000_0000
) (
    input  wire     clk_i,
    input  wire     rst_i,
    output wb_req_t bus_req_o,
    input  wb_rsp_t bus_rsp_i
);

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_REG_READ,
        ST_EXECUTE,
        ST_MEMORY,
        ST_REG_WRITE,
        ST_RESET
    } state_t;

    typedef struct packed {
        logic eq;
        logic neq;
        logic lt;
        logic ltu;
        logic ge;
        logic geu;
    } flags_t;

    state_t      state;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        is_load;
    logic        is_store;
    logic        writes_rd;

    logic        pc_count;
    logic        pc_load;
    logic [31:0] pc;
    logic [31:0] pc_inc;

    logic        w_en;
    logic [31:0] w_data;
    logic [31:0] rs1;
    logic [31:0] rs2;

    logic [31:0] alu_out;
    logic [31:0] alu_r;
    flags_t      flags;
    flags_t      flags_r;

    logic [1:0]  byte_off;
    logic [31:0] lane;
    logic [31:0] ld_data;
    logic [3:0]  st_sel;
    logic [31:0] st_dat;
    logic        taken;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign is_load   = opcode == OPCODE_LOAD;
    assign is_store  = opcode == OPCODE_STORE;
    assign writes_rd = opcode inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
                                      OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP};
    assign byte_off  = alu_r[1:0];

    program_counter #(.INITIAL_PC(INITIAL_PC)) pc_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .count_i  (pc_count),
        .load_i   (pc_load),
        .value_i  (alu_r),
        .pc_o     (pc),
        .pc_inc_o (pc_inc)
    );

    register_file regs_i (
        .clk_i     (clk_i),
        .r_addr1_i (instr[19:15]),
        .r_addr2_i (instr[24:20]),
        .r_data1_o (rs1),
        .r_data2_o (rs2),
        .w_en_i    (w_en),
        .w_addr_i  (instr[11:7]),
        .w_data_i  (w_data)
    );

    alu alu_i (
        .instr_i  (instr),
        .op_a_i   (rs1),
        .op_b_i   (rs2),
        .pc_i     (pc),
        .result_o (alu_out),
        .eq_o     (flags.eq),
        .neq_o    (flags.neq),
        .lt_o     (flags.lt),
        .ltu_o    (flags.ltu),
        .ge_o     (flags.ge),
        .geu_o    (flags.geu)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_RESET;
        end else begin
            case (state)
                ST_RESET:     state <= ST_FETCH;
                ST_FETCH:     if (bus_rsp_i.ack) state <= ST_REG_READ;
                ST_REG_READ:  state <= ST_EXECUTE;
                ST_EXECUTE:   state <= ST_MEMORY;
                // no bus cycle for non-memory instructions
                ST_MEMORY:    if (bus_rsp_i.ack || !(is_load || is_store)) state <= ST_REG_WRITE;
                ST_REG_WRITE: state <= ST_FETCH;
                default:      state <= ST_RESET;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == ST_FETCH && bus_rsp_i.ack) begin
            instr <= bus_rsp_i.dat;
        end
        if (state == ST_EXECUTE) begin
            alu_r   <= alu_out;
            flags_r <= flags;
        end
        if (state == ST_MEMORY && bus_rsp_i.ack) begin
            read_data <= bus_rsp_i.dat;
        end
    end

    // store lanes
    always_comb begin
        case (funct3)
            FUNCT3_SB: begin
                st_sel = 4'b0001 << byte_off;
                st_dat = rs2 << {byte_off, 3'b000};
            end
            FUNCT3_SH: begin
                st_sel = byte_off[1] ? 4'b1100 : 4'b0011;
                st_dat = rs2 << {byte_off[1], 4'b0000};
            end
            default: begin
                st_sel = 4'b1111;
                st_dat = rs2;
            end
        endcase
    end

    always_comb begin
        bus_req_o = '0;
        case (state)
            ST_FETCH: begin
                bus_req_o.cyc = 1'b1;
                bus_req_o.stb = 1'b1;
                bus_req_o.sel = 4'b1111;
                bus_req_o.adr = pc;
            end
            ST_MEMORY: begin
                if (is_load || is_store) begin
                    bus_req_o.cyc = 1'b1;
                    bus_req_o.stb = 1'b1;
                    bus_req_o.we  = is_store;
                    bus_req_o.sel = is_store ? st_sel : 4'b1111;
                    bus_req_o.adr = {alu_r[31:2], 2'b00};
                    bus_req_o.dat = st_dat;
                end
            end
            default: ;
        endcase
    end

    // load lane select and extend
    assign lane = read_data >> {byte_off, 3'b000};

    always_comb begin
        case (funct3)
            FUNCT3_LB:  ld_data = {{24{lane[7]}}, lane[7:0]};
            FUNCT3_LH:  ld_data = {{16{lane[15]}}, lane[15:0]};
            FUNCT3_LBU: ld_data = {24'd0, lane[7:0]};
            FUNCT3_LHU: ld_data = {16'd0, lane[15:0]};
            default:    ld_data = read_data;
        endcase
    end

    always_comb begin
        case (opcode)
            OPCODE_LOAD:             w_data = ld_data;
            OPCODE_JAL, OPCODE_JALR: w_data = pc_inc;
            default:                 w_data = alu_r;
        endcase
    end

    always_comb begin
        case (funct3)
            FUNCT3_BEQ:  taken = flags_r.eq;
            FUNCT3_BNE:  taken = flags_r.neq;
            FUNCT3_BLT:  taken = flags_r.lt;
            FUNCT3_BGE:  taken = flags_r.ge;
            FUNCT3_BLTU: taken = flags_r.ltu;
            FUNCT3_BGEU: taken = flags_r.geu;
            default:     taken = 1'b0;
        endcase
    end

    // fence, ecall, ebreak and csr fall through as no-ops
    assign w_en     = (state == ST_REG_WRITE) && writes_rd;
    assign pc_load  = (state == ST_REG_WRITE) &&
                      (opcode == OPCODE_JAL || opcode == OPCODE_JALR ||
                       (opcode == OPCODE_BRANCH && taken));
    assign pc_count = (state == ST_REG_WRITE) && !pc_load;

endmodule

`default_nettype wire

/* rtl/wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ram import rv_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wb_req_t     req_i,
    output wb_rsp_t     rsp_o,
    input  wire         prog_we_i,
    input  wire  [31:0] prog_adr_i,
    input  wire  [31:0] prog_dat_i
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;
    logic          ack;
    logic          wr_en;
    logic [31:0]   rdata;

    // word index wraps modulo RAM_WORDS
    assign idx   = req_i.adr[AW+1:2];
    assign wr_en = req_i.cyc && req_i.stb && req_i.we && !ack;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack <= 1'b0;
        end else begin
            ack <= req_i.cyc && req_i.stb && !ack;
        end
    end

    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            mem[prog_adr_i[AW-1:0]] <= prog_dat_i;
        end else if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.sel[i]) begin
                    mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
                end
            end
        end
        rdata <= mem[idx];
    end

    assign rsp_o.ack = ack;
    assign rsp_o.dat = rdata;

endmodule

`default_nettype wire

/* rtl/wb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_decoder import rv_pkg::*; #(
    parameter logic [31:0] PORT_ADDR = 32'h0000_1000
) (
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o,
    output wb_req_t ram_req_o,
    input  wb_rsp_t ram_rsp_i,
    output wb_req_t port_req_o,
    input  wb_rsp_t port_rsp_i
);

    logic port_hit;

    // port on an exact match, ram gets the rest
    assign port_hit = req_i.adr == PORT_ADDR;

    always_comb begin
        ram_req_o      = req_i;
        port_req_o     = req_i;
        ram_req_o.stb  = req_i.stb && !port_hit;
        port_req_o.stb = req_i.stb && port_hit;
        rsp_o          = port_hit ? port_rsp_i : ram_rsp_i;
    end

endmodule

`default_nettype wire

/* rtl/out_port.sv */
`timescale 1ns/1ps
`default_nettype none

module out_port import rv_pkg::*; (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wb_req_t     req_i,
    output wb_rsp_t     rsp_o,
    output logic [31:0] port_o,
    output logic        port_valid_o
);

    logic ack;
    logic req;

    assign req = req_i.cyc && req_i.stb && !ack;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack          <= 1'b0;
            port_valid_o <= 1'b0;
            port_o       <= 32'd0;
        end else begin
            ack          <= req;
            port_valid_o <= req && req_i.we;
            if (req && req_i.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (req_i.sel[i]) begin
                        port_o[8*i +: 8] <= req_i.dat[8*i +: 8];
                    end
                end
            end
        end
    end

    assign rsp_o.ack = ack;
    assign rsp_o.dat = port_o;

endmodule

`default_nettype wire

/* rtl/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top import rv_pkg::*; #(
    parameter logic [31:0] INITIAL_PC = 32'h0000_0000,
    parameter int          RAM_WORDS  = 1024,
    parameter logic [31:0] PORT_ADDR  = 32'h0000_1000
) (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         prog_we_i,
    input  wire  [31:0] prog_adr_i,
    input  wire  [31:0] prog_dat_i,
    output logic [31:0] port_o,
    output logic        port_valid_o
);

    wb_req_t cpu_req;
    wb_rsp_t cpu_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    wb_req_t port_req;
    wb_rsp_t port_rsp;

    cpu #(.INITIAL_PC(INITIAL_PC)) cpu_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_req_o (cpu_req),
        .bus_rsp_i (cpu_rsp)
    );

    wb_decoder #(.PORT_ADDR(PORT_ADDR)) dec_i (
        .req_i      (cpu_req),
        .rsp_o      (cpu_rsp),
        .ram_req_o  (ram_req),
        .ram_rsp_i  (ram_rsp),
        .port_req_o (port_req),
        .port_rsp_i (port_rsp)
    );

    wb_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (ram_req),
        .rsp_o      (ram_rsp),
        .prog_we_i  (prog_we_i),
        .prog_adr_i (prog_adr_i),
        .prog_dat_i (prog_dat_i)
    );

    out_port port_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (port_req),
        .rsp_o        (port_rsp),
        .port_o       (port_o),
        .port_valid_o (port_valid_o)
    );

endmodule

`default_nettype wire

/* test/soc_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_sva import rv_pkg::*; (
    input wire     clk_i,
    input wire     rst_i,
    input wb_req_t bus_req_o,
    input wb_rsp_t bus_rsp_i
);

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_req_o.stb |-> bus_req_o.cyc)
        else $error("stb high without cyc");

    // master holds the request until the slave acks
    req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (bus_req_o.stb && !bus_rsp_i.ack) |=> $stable(bus_req_o))
        else $error("request changed while waiting for ack");

    // the reset is synchronous, so the first reset edge may still see a strobe
    no_stb_in_reset: assert property (@(posedge clk_i)
        (rst_i && $past(rst_i)) |-> !bus_req_o.stb)
        else $error("stb high during reset");

endmodule

bind cpu soc_sva sva_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_req_o (bus_req_o),
    .bus_rsp_i (bus_rsp_i)
);

`default_nettype wire

/* test/tb_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc import rv_pkg::*; ();

    localparam logic [31:0] PORT_ADDR = 32'h0000_1000;
    // six tests of up to about 80 instructions at 7 cycles, with margin
    localparam int CYCLE_LIMIT = 4000;
    localparam int PULSE_WAIT  = 400;

    logic        clk;
    logic        rst_i;
    logic        prog_we_i;
    logic [31:0] prog_adr_i;
    logic [31:0] prog_dat_i;
    wire  [31:0] port_o;
    wire         port_valid_o;

    logic [31:0] prog_q[$];
    logic [31:0] exp_q[$];
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;
    logic [2:0]  branch_kinds [6];

    soc_top #(
        .INITIAL_PC (32'h0000_0000),
        .RAM_WORDS  (1024),
        .PORT_ADDR  (PORT_ADDR)
    ) dut_i (
        .clk_i        (clk),
        .rst_i        (rst_i),
        .prog_we_i    (prog_we_i),
        .prog_adr_i   (prog_adr_i),
        .prog_dat_i   (prog_dat_i),
        .port_o       (port_o),
        .port_valid_o (port_valid_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // arithmetic right shift built from logical shifts
    function automatic logic [31:0] shift_right_arith(input logic [31:0] a,
                                                      input logic [4:0] sh);
        return a[31] ? ~(~a >> sh) : a >> sh;
    endfunction

    // signs decide first, equal signs compare as unsigned
    function automatic logic less_signed(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : a < b;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            FUNCT3_BEQ:  return a == b;
            FUNCT3_BNE:  return a != b;
            FUNCT3_BLT:  return $signed(a) < $signed(b);
            FUNCT3_BGE:  return $signed(a) >= $signed(b);
            FUNCT3_BLTU: return a < b;
            default:     return a >= b;
        endcase
    endfunction

    // address of the next instruction, the program starts at zero
    function automatic logic [31:0] next_pc();
        return 32'(4 * prog_q.size());
    endfunction

    task automatic emit(input logic [31:0] w);
        prog_q.push_back(w);
    endtask

    task automatic begin_program();
        prog_q.delete();
        exp_q.delete();
        // x31 holds the port address
        emit(u_type(PORT_ADDR[31:12], 5'd31, OPCODE_LUI));
    endtask

    task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = (v + 32'h800) >> 12;
        emit(u_type(hi[19:0], rd, OPCODE_LUI));
        emit(i_type(v, rd, FUNCT3_ADD_SUB, rd, OPCODE_OP_IMM));
    endtask

    task automatic report(input logic [4:0] rs);
        emit(s_type(32'd0, rs, 5'd31, FUNCT3_SW));
    endtask

    task automatic check_next_port(input logic [31:0] expected);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!port_valid_o && waited < PULSE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (!port_valid_o) begin
            errors++;
            $display("no port write seen within %0d cycles at %0t", PULSE_WAIT, $time);
        end else if (port_o !== expected) begin
            errors++;
            $display("Error at %0t: port_o %h, expected %h", $time, port_o, expected);
        end
    endtask

    task automatic run_program();
        logic [31:0] e;
        // park the core in a self loop at the end
        emit(j_type(32'd0, 5'd0));
        @(negedge clk);
        rst_i = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (port_valid_o) begin
                errors++;
                $display("port_valid_o went high during reset at %0t", $time);
            end
        end
        for (int i = 0; i < prog_q.size(); i++) begin
            prog_we_i  = 1'b1;
            prog_adr_i = i;
            prog_dat_i = prog_q[i];
            @(negedge clk);
        end
        prog_we_i = 1'b0;
        rst_i     = 1'b0;
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_next_port(e);
        end
        repeat (20) begin
            @(negedge clk);
            if (port_valid_o) begin
                errors++;
                $display("unexpected port write of %h at %0t", port_o, $time);
            end
        end
    endtask

    task automatic test_reset();
        begin_program();
        load_imm(5'd1, 32'h5a);
        report(5'd1);
        exp_q.push_back(32'h5a);
        run_program();
    endtask

    task automatic op_check(input logic [6:0] f7, input logic [2:0] f3,
                            input logic [31:0] expected);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
        report(5'd3);
        exp_q.push_back(expected);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        a = rand_bits(32);
        b = rand_bits(32);
        begin_program();
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        op_check(7'h00, FUNCT3_ADD_SUB, a + b);
        op_check(7'h20, FUNCT3_ADD_SUB, a - b);
        op_check(7'h00, FUNCT3_XOR, a ^ b);
        op_check(7'h00, FUNCT3_OR, a | b);
        op_check(7'h00, FUNCT3_AND, a & b);
        op_check(7'h00, FUNCT3_SLL, a << b[4:0]);
        op_check(7'h00, FUNCT3_SR, a >> b[4:0]);
        op_check(7'h20, FUNCT3_SR, shift_right_arith(a, b[4:0]));
        op_check(7'h00, FUNCT3_SLT, {31'd0, less_signed(a, b)});
        op_check(7'h00, FUNCT3_SLTU, {31'd0, a < b});
        // srai by 7
        emit(i_type(32'h407, 5'd1, FUNCT3_SR, 5'd3, OPCODE_OP_IMM));
        report(5'd3);
        exp_q.push_back(shift_right_arith(a, 5'd7));
        run_program();
    endtask

    task automatic test_mem();
        logic [31:0] w;
        logic [31:0] v;
        logic [31:0] p;
        logic [7:0]  by;
        logic [15:0] hw;
        w = rand_bits(32);
        v = rand_bits(16);
        begin_program();
        load_imm(5'd1, w);
        load_imm(5'd2, 32'h800);
        emit(s_type(32'd0, 5'd1, 5'd2, FUNCT3_SW));
        for (int off = 0; off < 4; off++) begin
            by = w[8*off +: 8];
            emit(i_type(off, 5'd2, FUNCT3_LB, 5'd3, OPCODE_LOAD));
            report(5'd3);
            exp_q.push_back({{24{by[7]}}, by});
            emit(i_type(off, 5'd2, FUNCT3_LBU, 5'd3, OPCODE_LOAD));
            report(5'd3);
            exp_q.push_back({24'd0, by});
        end
        for (int off = 0; off < 4; off += 2) begin
            hw = w[8*off +: 16];
            emit(i_type(off, 5'd2, FUNCT3_LH, 5'd3, OPCODE_LOAD));
            report(5'd3);
            exp_q.push_back({{16{hw[15]}}, hw});
            emit(i_type(off, 5'd2, FUNCT3_LHU, 5'd3, OPCODE_LOAD));
            report(5'd3);
            exp_q.push_back({16'd0, hw});
        end
        emit(i_type(32'd0, 5'd2, FUNCT3_LW, 5'd3, OPCODE_LOAD));
        report(5'd3);
        exp_q.push_back(w);
        // partial writes to the port only touch their lanes
        report(5'd1);
        exp_q.push_back(w);
        load_imm(5'd4, v);
        emit(s_type(32'd1, 5'd4, 5'd31, FUNCT3_SB));
        p = {w[31:16], v[7:0], w[7:0]};
        exp_q.push_back(p);
        emit(s_type(32'd2, 5'd4, 5'd31, FUNCT3_SH));
        p = {v[15:0], p[15:0]};
        exp_q.push_back(p);
        // port reads return the register
        emit(i_type(32'd0, 5'd31, FUNCT3_LW, 5'd3, OPCODE_LOAD));
        report(5'd3);
        exp_q.push_back(p);
        // same partial writes into ram, read back as a word
        emit(s_type(32'd1, 5'd4, 5'd2, FUNCT3_SB));
        emit(s_type(32'd2, 5'd4, 5'd2, FUNCT3_SH));
        emit(i_type(32'd0, 5'd2, FUNCT3_LW, 5'd3, OPCODE_LOAD));
        report(5'd3);
        exp_q.push_back({v[15:0], v[7:0], w[7:0]});
        run_program();
    endtask

    task automatic test_branch();
        logic [31:0] n;
        logic [31:0] pa [3];
        logic [31:0] pb [3];
        int          k;
        n     = rand_bits(3) + 1;
        pa[0] = -32'sd3;
        pb[0] = 32'd5;
        pa[1] = 32'd5;
        pb[1] = 32'd5;
        pa[2] = 32'd5;
        pb[2] = -32'sd3;
        k     = 0;
        begin_program();
        load_imm(5'd3, n + 1);
        for (int loop = 0; loop < 2; loop++) begin
            emit(i_type(32'd0, 5'd0, FUNCT3_ADD_SUB, 5'd1, OPCODE_OP_IMM));
            emit(i_type(32'd1, 5'd0, FUNCT3_ADD_SUB, 5'd2, OPCODE_OP_IMM));
            emit(r_type(7'h00, 5'd2, 5'd1, FUNCT3_ADD_SUB, 5'd1));
            emit(i_type(32'd1, 5'd2, FUNCT3_ADD_SUB, 5'd2, OPCODE_OP_IMM));
            emit(b_type(-32'sd8, 5'd3, 5'd2, (loop == 0) ? FUNCT3_BNE : FUNCT3_BLT));
            report(5'd1);
            exp_q.push_back(n * (n + 1) / 2);
        end
        for (int p = 0; p < 3; p++) begin
            load_imm(5'd5, pa[p]);
            load_imm(5'd6, pb[p]);
            for (int j = 0; j < 6; j++) begin
                emit(b_type(32'd16, 5'd6, 5'd5, branch_kinds[j]));
                emit(i_type(32'h100 + 2 * k, 5'd0, FUNCT3_ADD_SUB, 5'd7, OPCODE_OP_IMM));
                report(5'd7);
                emit(j_type(32'd12, 5'd0));
                emit(i_type(32'h101 + 2 * k, 5'd0, FUNCT3_ADD_SUB, 5'd7, OPCODE_OP_IMM));
                report(5'd7);
                exp_q.push_back(32'h100 + 2 * k + int'(branch_taken(branch_kinds[j],
                                                                    pa[p], pb[p])));
                k++;
            end
        end
        run_program();
    endtask

    task automatic test_jump();
        logic [31:0] p;
        logic [31:0] t;
        begin_program();
        p = next_pc();
        emit(j_type(32'd12, 5'd1));
        emit(i_type(32'h0bd, 5'd0, FUNCT3_ADD_SUB, 5'd7, OPCODE_OP_IMM));
        report(5'd7);
        report(5'd1);
        exp_q.push_back(p + 4);
        // jalr sits right after the addi, odd offset checks bit 0 clearing
        p = next_pc() + 4;
        t = p + 12;
        emit(i_type(t, 5'd0, FUNCT3_ADD_SUB, 5'd5, OPCODE_OP_IMM));
        emit(i_type(32'd1, 5'd5, 3'b000, 5'd6, OPCODE_JALR));
        emit(i_type(32'h0bd, 5'd0, FUNCT3_ADD_SUB, 5'd7, OPCODE_OP_IMM));
        report(5'd7);
        report(5'd6);
        exp_q.push_back(p + 4);
        run_program();
    endtask

    task automatic test_upper();
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] p;
        v = rand_bits(20);
        w = rand_bits(20);
        begin_program();
        emit(u_type(v[19:0], 5'd8, OPCODE_LUI));
        report(5'd8);
        exp_q.push_back(v << 12);
        p = next_pc();
        emit(u_type(w[19:0], 5'd9, OPCODE_AUIPC));
        report(5'd9);
        exp_q.push_back(p + (w << 12));
        run_program();
    endtask

    initial begin
        clk             = 1'b0;
        rst_i           = 1'b1;
        prog_we_i       = 1'b0;
        prog_adr_i      = '0;
        prog_dat_i      = '0;
        lfsr            = 16'd75;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        branch_kinds[0] = FUNCT3_BEQ;
        branch_kinds[1] = FUNCT3_BNE;
        branch_kinds[2] = FUNCT3_BLT;
        branch_kinds[3] = FUNCT3_BGE;
        branch_kinds[4] = FUNCT3_BLTU;
        branch_kinds[5] = FUNCT3_BGEU;
        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_jump();
        test_upper();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/rv_pkg.sv
rtl/program_counter.sv
rtl/register_file.sv
rtl/alu.sv
rtl/cpu.sv
rtl/wb_ram.sv
rtl/wb_decoder.sv
rtl/out_port.sv
rtl/soc_top.sv
test/soc_sva.sv
test/tb_soc.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, then look for the fail message in the log
verilator --binary --timing --assert -f all.f --top-module tb_soc -o sim_soc > build.log 2>&1 \
    && ./obj_dir/sim_soc > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0
